// File: lspCompose.f
src/lspComposePkg.sv
src/scratchMemory.sv
src/fixedPointMac.sv
src/composeIndexCounter.sv
src/composeController.sv
src/hostMemoryPort.sv
src/lspComposeTop.sv
sim/lspComposeTb.sv

// File: sim/lspComposeTb.sv
module lspComposeTb;
	timeunit 1ns;
	timeprecision 100ps;

	import lspComposePkg::*;

	localparam int TIMEOUT_CYCLES = 20000;
	localparam int ACK_LIMIT = 400;
	localparam int DONE_LIMIT = 400;
	localparam int SCAN_COUNT = 24;
	localparam longint POS_LIMIT = 64'sd2147483647;
	localparam longint NEG_LIMIT = -64'sd2147483648;

	logic clk = 1'b0;
	logic reset;
	logic start;
	wbRequest bus;
	wbResponse reply;
	logic busy;
	logic done;
	logic overflow;

	// Operand images of the scratch memory regions
	logic signed [OP_WIDTH-1:0] lspEle [LSP_ORDER];
	logic signed [OP_WIDTH-1:0] fgSum [LSP_ORDER];
	logic signed [OP_WIDTH-1:0] freqPrev [MA_ORDER][LSP_ORDER];
	logic signed [OP_WIDTH-1:0] fg [MA_ORDER][LSP_ORDER];
	logic [DATA_WIDTH-1:0] expOut [LSP_ORDER];
	logic refOverflow;

	logic [31:0] lfsrState = 32'hc23d;
	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;
	int doneCount = 0;
	int doneMark;

	// Pending comparisons drained by the checker process
	logic [DATA_WIDTH-1:0] gotQ [$];
	logic [DATA_WIDTH-1:0] expQ [$];
	string nameQ [$];

	lspComposeTop dut0 (.clk(clk), .reset(reset), .start(start), .bus(bus), .reply(reply),
		.busy(busy), .done(done), .overflow(overflow));

	always #10 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////////////////////////

	// Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsrBit();
		logic outBit;
		outBit = lfsrState[0];
		lfsrState = lfsrState >> 1;
		if (outBit)
			lfsrState = lfsrState ^ 32'h8020_0003;
		return outBit;
	endfunction

	function automatic logic [31:0] randomBits(int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++)
			value = {value[30:0], lfsrBit()};
		return value;
	endfunction

	// Inputs change 2 ns after the rising edge
	task automatic nextCycle();
		@(posedge clk);
		#2;
	endtask

	// One Wishbone classic transfer with the request held until ack
	task automatic busTransfer(input logic we, input logic [ADDR_WIDTH-1:0] adr,
		input logic [DATA_WIDTH-1:0] dat, output logic [DATA_WIDTH-1:0] rdat);
		int waited;
		nextCycle();
		bus.cyc = 1'b1;
		bus.stb = 1'b1;
		bus.we = we;
		bus.adr = adr;
		bus.dat = dat;
		waited = 0;
		do
		begin
			nextCycle();
			waited++;
		end
		while (!reply.ack && waited < ACK_LIMIT);
		if (!reply.ack)
		begin
			errorCount++;
			$display("Wishbone transfer to address %h got no ack in %0d cycles", adr, ACK_LIMIT);
		end
		rdat = reply.dat;
		bus.cyc = 1'b0;
		bus.stb = 1'b0;
		bus.we = 1'b0;
	endtask

	task automatic writeOperand(input logic [ADDR_WIDTH-1:0] adr, input logic [15:0] value);
		logic [DATA_WIDTH-1:0] unused;
		busTransfer(1'b1, adr, {{16{value[15]}}, value}, unused);
	endtask

	task automatic expectValue(input string name, input logic [DATA_WIDTH-1:0] got,
		input logic [DATA_WIDTH-1:0] expected);
		nameQ.push_back(name);
		gotQ.push_back(got);
		expQ.push_back(expected);
	endtask

	task automatic readExpect(input string name, input logic [ADDR_WIDTH-1:0] adr,
		input logic [DATA_WIDTH-1:0] expected);
		logic [DATA_WIDTH-1:0] word;
		busTransfer(1'b0, adr, '0, word);
		expectValue(name, word, expected);
	endtask

	task automatic storeFg();
		for (int k = 0; k < MA_ORDER; k++)
			for (int j = 0; j < LSP_ORDER; j++)
				writeOperand(FG_BASE + ADDR_WIDTH'(k * 16 + j), fg[k][j]);
	endtask

	task automatic storeAll();
		for (int j = 0; j < LSP_ORDER; j++)
		begin
			writeOperand(LSP_ELE_BASE + ADDR_WIDTH'(j), lspEle[j]);
			writeOperand(FG_SUM_BASE + ADDR_WIDTH'(j), fgSum[j]);
		end
		for (int k = 0; k < MA_ORDER; k++)
			for (int j = 0; j < LSP_ORDER; j++)
				writeOperand(FREQ_PREV_BASE + ADDR_WIDTH'(k * 16 + j), freqPrev[k][j]);
		storeFg();
	endtask

	// One-cycle start pulse with busy expected on the next edge
	task automatic startEngine();
		doneMark = doneCount;
		nextCycle();
		start = 1'b1;
		nextCycle();
		start = 1'b0;
		expectValue("busy", busy, 1);
	endtask

	task automatic waitDone();
		int waited;
		waited = 0;
		while (doneCount == doneMark && waited < DONE_LIMIT)
		begin
			nextCycle();
			waited++;
		end
		if (doneCount == doneMark)
		begin
			errorCount++;
			$display("Engine gave no done pulse within %0d cycles", DONE_LIMIT);
		end
	endtask

	task automatic checkResults();
		for (int j = 0; j < LSP_ORDER; j++)
			readExpect($sformatf("lspOut[%0d]", j), LSP_OUT_BASE + ADDR_WIDTH'(j), expOut[j]);
		expectValue("overflow", overflow, refOverflow);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	// Clamp to the signed 32-bit range
	function automatic longint saturate(longint value);
		if (value > POS_LIMIT)
		begin
			refOverflow = 1'b1;
			return POS_LIMIT;
		end
		if (value < NEG_LIMIT)
		begin
			refOverflow = 1'b1;
			return NEG_LIMIT;
		end
		return value;
	endfunction

	// acc = sat(2 lsp fgSum) and then acc = sat(acc + sat(2 freqPrev fg)) per stage
	function automatic void computeReference();
		longint acc;
		longint product;
		refOverflow = 1'b0;
		for (int j = 0; j < LSP_ORDER; j++)
		begin
			product = longint'(lspEle[j]) * longint'(fgSum[j]);
			acc = saturate(2 * product);
			for (int k = 0; k < MA_ORDER; k++)
			begin
				product = longint'(freqPrev[k][j]) * longint'(fg[k][j]);
				acc = saturate(acc + saturate(2 * product));
			end
			// Sign-extended high half
			expOut[j] = 32'(acc >>> 16);
		end
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Checking and monitors
	//////////////////////////////////////////////////////////////////////
	task automatic checkValue(input string name, input logic [DATA_WIDTH-1:0] got,
		input logic [DATA_WIDTH-1:0] expected);
		checkCount++;
		if (got !== expected)
		begin
			errorCount++;
			$display("ERROR time %0t %s: got %h, expected %h", $time, name, got, expected);
		end
	endtask

	always @(posedge clk)
	begin
		while (gotQ.size() > 0)
			checkValue(nameQ.pop_front(), gotQ.pop_front(), expQ.pop_front());
	end

	// Done pulses and the busy hold-off
	always @(posedge clk)
	begin
		if (!reset && done)
			doneCount++;
		if (!reset && busy && reply.ack)
		begin
			errorCount++;
			$display("Wishbone ack seen while the engine was busy at %0t", $time);
		end
	end

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount >= TIMEOUT_CYCLES)
		begin
			$display("Timeout after %0d cycles", TIMEOUT_CYCLES);
			$display("Checks: %0d, errors: %0d", checkCount, errorCount);
			$display("Done: errors found");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Scenarios
	//////////////////////////////////////////////////////////////////////
	initial
	begin : mainFlow
		logic [ADDR_WIDTH-1:0] scanAddr [SCAN_COUNT];
		logic [DATA_WIDTH-1:0] scanData [SCAN_COUNT];
		logic [DATA_WIDTH-1:0] word;
		reset = 1'b1;
		start = 1'b0;
		bus = '0;
		repeat (8) @(posedge clk);
		#2;
		reset = 1'b0;

		// Plain write and read back across the whole map
		for (int i = 0; i < SCAN_COUNT; i++)
		begin
			scanAddr[i] = ADDR_WIDTH'(i * 85) + ADDR_WIDTH'(randomBits(6));
			scanData[i] = randomBits(32);
			busTransfer(1'b1, scanAddr[i], scanData[i], word);
		end
		for (int i = 0; i < SCAN_COUNT; i++)
			readExpect($sformatf("mem[%h]", scanAddr[i]), scanAddr[i], scanData[i]);

		// Random operands everywhere
		for (int j = 0; j < LSP_ORDER; j++)
		begin
			lspEle[j] = OP_WIDTH'(randomBits(16));
			fgSum[j] = OP_WIDTH'(randomBits(16));
			for (int k = 0; k < MA_ORDER; k++)
			begin
				freqPrev[k][j] = OP_WIDTH'(randomBits(16));
				fg[k][j] = OP_WIDTH'(randomBits(16));
			end
		end
		storeAll();
		computeReference();
		startEngine();
		waitDone();
		checkResults();

		// Saturation with every operand at -32768
		for (int j = 0; j < LSP_ORDER; j++)
		begin
			lspEle[j] = 16'sh8000;
			fgSum[j] = 16'sh8000;
			for (int k = 0; k < MA_ORDER; k++)
			begin
				freqPrev[k][j] = 16'sh8000;
				fg[k][j] = 16'sh8000;
			end
		end
		storeAll();
		computeReference();
		startEngine();
		waitDone();
		checkResults();
		expectValue("overflowSaturated", overflow, 1);

		// Host read while the engine owns the memory
		startEngine();
		busTransfer(1'b0, FG_BASE + ADDR_WIDTH'(3 * 16 + 3), '0, word);
		expectValue("doneBeforeAck", doneCount != doneMark, 1);
		expectValue("heldRead", word, {{16{fg[3][3][15]}}, fg[3][3]});

		// Second run with new predictor coefficients
		for (int k = 0; k < MA_ORDER; k++)
			for (int j = 0; j < LSP_ORDER; j++)
				fg[k][j] = OP_WIDTH'(randomBits(16));
		storeFg();
		computeReference();
		startEngine();
		expectValue("overflowAtStart", overflow, 0);
		waitDone();
		checkResults();
		for (int j = 0; j < LSP_ORDER; j++)
		begin
			readExpect("lspEle", LSP_ELE_BASE + ADDR_WIDTH'(j), {{16{lspEle[j][15]}}, lspEle[j]});
			readExpect("fgSum", FG_SUM_BASE + ADDR_WIDTH'(j), {{16{fgSum[j][15]}}, fgSum[j]});
			for (int k = 0; k < MA_ORDER; k++)
			begin
				readExpect("freqPrev", FREQ_PREV_BASE + ADDR_WIDTH'(k * 16 + j),
					{{16{freqPrev[k][j][15]}}, freqPrev[k][j]});
				readExpect("fg", FG_BASE + ADDR_WIDTH'(k * 16 + j), {{16{fg[k][j][15]}}, fg[k][j]});
			end
		end

		// Let the checker drain
		while (gotQ.size() > 0)
			nextCycle();
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// File: src/lspComposeTop.sv
module lspComposeTop
(
	input logic clk,
	input logic reset,
	input logic start,
	input lspComposePkg::wbRequest bus,
	output lspComposePkg::wbResponse reply,
	output logic busy,
	output logic done,
	output logic overflow
);
	import lspComposePkg::*;

	// Memory side
	logic [ADDR_WIDTH-1:0] engineReadAddr;
	logic [ADDR_WIDTH-1:0] memReadAddr;
	logic [DATA_WIDTH-1:0] memReadData;
	memWrite engineWrite;
	memWrite memWriteBus;

	// Arithmetic side
	macCommand macCmd;
	logic [DATA_WIDTH-1:0] accumulator;
	logic clearFlag;

	// Loop indices
	logic clearCount;
	logic stepStage;
	logic stepCoeff;
	logic [COEFF_WIDTH-1:0] coeffIndex;
	logic [STAGE_WIDTH-1:0] stageIndex;
	logic lastStage;
	logic lastCoeff;

	composeController controller (.clk(clk), .reset(reset), .start(start),
		.coeffIndex(coeffIndex), .stageIndex(stageIndex), .lastStage(lastStage),
		.lastCoeff(lastCoeff), .readData(memReadData), .accumulator(accumulator),
		.readAddr(engineReadAddr), .command(macCmd), .write(engineWrite),
		.clearCount(clearCount), .stepStage(stepStage), .stepCoeff(stepCoeff),
		.clearFlag(clearFlag), .busy(busy), .done(done));

	composeIndexCounter indexCounter (.clk(clk), .reset(reset), .clear(clearCount),
		.stepStage(stepStage), .stepCoeff(stepCoeff), .coeffIndex(coeffIndex),
		.stageIndex(stageIndex), .lastStage(lastStage), .lastCoeff(lastCoeff));

	fixedPointMac mac (.clk(clk), .reset(reset), .command(macCmd), .clearFlag(clearFlag),
		.accumulator(accumulator), .overflow(overflow));

	// Host takes the memory whenever the engine is idle
	hostMemoryPort hostPort (.clk(clk), .reset(reset), .bus(bus), .reply(reply),
		.busy(busy), .engineReadAddr(engineReadAddr), .engineWrite(engineWrite),
		.memReadAddr(memReadAddr), .memWriteOut(memWriteBus), .memReadData(memReadData));

	scratchMemory memory (.clk(clk), .write(memWriteBus), .readAddr(memReadAddr),
		.readData(memReadData));

endmodule

// File: src/hostMemoryPort.sv
module hostMemoryPort
(
	input logic clk,
	input logic reset,
	input lspComposePkg::wbRequest bus,
	output lspComposePkg::wbResponse reply,
	input logic busy,
	input logic [lspComposePkg::ADDR_WIDTH-1:0] engineReadAddr,
	input lspComposePkg::memWrite engineWrite,
	output logic [lspComposePkg::ADDR_WIDTH-1:0] memReadAddr,
	output lspComposePkg::memWrite memWriteOut,
	input logic [lspComposePkg::DATA_WIDTH-1:0] memReadData
);
	import lspComposePkg::*;

	logic hostRequest;
	logic hostGrant;
	logic ackReg;

	//////////////////////////////////////////////////////////////////////
	// Wishbone handshake
	//////////////////////////////////////////////////////////////////////
	assign hostRequest = bus.cyc && bus.stb;
	// Engine owns the memory while busy, held-off request waits
	// No second grant during the ack cycle itself
	assign hostGrant = hostRequest && !busy && !ackReg;

	// Single-cycle ack, one cycle after the grant
	always_ff @(posedge clk)
	begin
		if (reset)
			ackReg <= 1'b0;
		else
			ackReg <= hostGrant;
	end

	// Read word is registered on the grant edge, so it lines up with ack
	assign reply.ack = ackReg;
	assign reply.dat = memReadData;

	//////////////////////////////////////////////////////////////////////
	// Memory port select
	//////////////////////////////////////////////////////////////////////
	assign memReadAddr = busy ? engineReadAddr : bus.adr;

	always_comb
	begin
		if (busy)
			memWriteOut = engineWrite;
		else
		begin
			// Host write commits on the same edge as the ack
			memWriteOut.en = hostGrant && bus.we;
			memWriteOut.adr = bus.adr;
			memWriteOut.dat = bus.dat;
		end
	end

	// No ack once the engine has held the memory for a full cycle
	assert property (@(posedge clk) disable iff (reset)
		busy && $past(busy) |-> !reply.ack);

endmodule

// File: src/composeController.sv
module composeController
(
	input logic clk,
	input logic reset,
	input logic start,
	input logic [lspComposePkg::COEFF_WIDTH-1:0] coeffIndex,
	input logic [lspComposePkg::STAGE_WIDTH-1:0] stageIndex,
	input logic lastStage,
	input logic lastCoeff,
	input logic [lspComposePkg::DATA_WIDTH-1:0] readData,
	input logic [lspComposePkg::DATA_WIDTH-1:0] accumulator,
	output logic [lspComposePkg::ADDR_WIDTH-1:0] readAddr,
	output lspComposePkg::macCommand command,
	output lspComposePkg::memWrite write,
	output logic clearCount,
	output logic stepStage,
	output logic stepCoeff,
	output logic clearFlag,
	output logic busy,
	output logic done
);
	import lspComposePkg::*;

	composeState state;
	composeState nextState;
	// Set while the lsp times fgSum pass runs
	logic firstPass;
	logic launch;
	logic [OP_WIDTH-1:0] operandX;
	logic [ADDR_WIDTH-1:0] stageOffset;
	logic [ADDR_WIDTH-1:0] xAddr;
	logic [ADDR_WIDTH-1:0] yAddr;

	//////////////////////////////////////////////////////////////////////
	// Status and start
	//////////////////////////////////////////////////////////////////////
	assign busy = (state != IDLE) && (state != FINISH);
	assign done = (state == FINISH);
	// Start only counts while the engine is free
	assign launch = start && !busy;
	assign clearCount = launch;
	assign clearFlag = launch;

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= IDLE;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = state;
		case (state)
			IDLE, FINISH: nextState = launch ? FETCH_X : IDLE;
			FETCH_X: nextState = FETCH_Y;
			FETCH_Y: nextState = ACCUMULATE;
			ACCUMULATE: nextState = (!firstPass && lastStage) ? WRITE_BACK : FETCH_X;
			WRITE_BACK: nextState = lastCoeff ? FINISH : FETCH_X;
			default: nextState = IDLE;
		endcase
	end

	// Pass tracking across one coefficient
	always_ff @(posedge clk)
	begin
		if (reset || launch)
			firstPass <= 1'b1;
		else if (state == ACCUMULATE)
			firstPass <= 1'b0;
		else if (state == WRITE_BACK)
			firstPass <= 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// Operand fetch
	//////////////////////////////////////////////////////////////////////
	assign stageOffset = ADDR_WIDTH'(stageIndex) * STAGE_STRIDE;
	assign xAddr = (firstPass ? LSP_ELE_BASE : FREQ_PREV_BASE + stageOffset)
		+ ADDR_WIDTH'(coeffIndex);
	assign yAddr = (firstPass ? FG_SUM_BASE : FG_BASE + stageOffset)
		+ ADDR_WIDTH'(coeffIndex);
	assign readAddr = (state == FETCH_Y) ? yAddr : xAddr;

	// X word arrives during FETCH_Y
	always_ff @(posedge clk)
	begin
		if (state == FETCH_Y)
			operandX <= readData[OP_WIDTH-1:0];
	end

	// Y word arrives during ACCUMULATE and goes straight to the MAC
	always_comb
	begin
		command.opcode = MAC_NONE;
		if (state == ACCUMULATE)
			command.opcode = firstPass ? MAC_MULT : MAC_ACCUM;
		command.operandA = operandX;
		command.operandB = readData[OP_WIDTH-1:0];
	end

	assign stepStage = (state == ACCUMULATE) && !firstPass && !lastStage;
	assign stepCoeff = (state == WRITE_BACK) && !lastCoeff;

	//////////////////////////////////////////////////////////////////////
	// Sign-extended write-back of the high half
	//////////////////////////////////////////////////////////////////////
	always_comb
	begin
		write.en = (state == WRITE_BACK);
		write.adr = LSP_OUT_BASE + ADDR_WIDTH'(coeffIndex);
		write.dat = {{OP_WIDTH{accumulator[DATA_WIDTH-1]}}, accumulator[DATA_WIDTH-1:OP_WIDTH]};
	end

	// Write-back only once the last predictor stage is in
	assert property (@(posedge clk) disable iff (reset)
		write.en |-> state == WRITE_BACK && lastStage);
	// done only after the final coefficient and with busy low
	assert property (@(posedge clk) disable iff (reset)
		done |-> !busy && lastCoeff && lastStage);

endmodule

// File: src/composeIndexCounter.sv
module composeIndexCounter
(
	input logic clk,
	input logic reset,
	input logic clear,
	input logic stepStage,
	input logic stepCoeff,
	output logic [lspComposePkg::COEFF_WIDTH-1:0] coeffIndex,
	output logic [lspComposePkg::STAGE_WIDTH-1:0] stageIndex,
	output logic lastStage,
	output logic lastCoeff
);
	import lspComposePkg::*;

	// Outer loop over coefficients, inner loop over predictor stages
	always_ff @(posedge clk)
	begin
		if (reset || clear)
		begin
			coeffIndex <= '0;
			stageIndex <= '0;
		end
		else if (stepCoeff)
		begin
			// New coefficient restarts the stage loop
			coeffIndex <= coeffIndex + 1'b1;
			stageIndex <= '0;
		end
		else if (stepStage)
		begin
			stageIndex <= stageIndex + 1'b1;
		end
	end

	// Last index flags
	assign lastStage = (stageIndex == STAGE_WIDTH'(MA_ORDER - 1));
	assign lastCoeff = (coeffIndex == COEFF_WIDTH'(LSP_ORDER - 1));

	// Controller never steps past the final coefficient
	assert property (@(posedge clk) disable iff (reset)
		coeffIndex < COEFF_WIDTH'(LSP_ORDER));

endmodule

// File: src/fixedPointMac.sv
module fixedPointMac
(
	input logic clk,
	input logic reset,
	input lspComposePkg::macCommand command,
	input logic clearFlag,
	output logic [lspComposePkg::DATA_WIDTH-1:0] accumulator,
	output logic overflow
);
	import lspComposePkg::*;

	logic signed [DATA_WIDTH-1:0] product;
	logic signed [DATA_WIDTH-1:0] doubled;
	logic productSaturated;
	logic signed [DATA_WIDTH:0] sum;
	logic [DATA_WIDTH-1:0] sumClamped;
	logic sumSaturated;

	//////////////////////////////////////////////////////////////////////
	// Doubled product and saturating sum
	//////////////////////////////////////////////////////////////////////
	always_comb
	begin
		// Full Q30 product fits in 32 bits
		product = $signed(command.operandA) * $signed(command.operandB);
		// Only -32768 squared leaves the range once doubled
		productSaturated = (product == 32'sh4000_0000);
		doubled = productSaturated ? $signed(WORD_MAX) : (product <<< 1);
		// One guard bit for the add
		sum = $signed({accumulator[DATA_WIDTH-1], accumulator})
			+ $signed({doubled[DATA_WIDTH-1], doubled});
		sumSaturated = (sum[DATA_WIDTH] != sum[DATA_WIDTH-1]);
		if (!sumSaturated)
			sumClamped = sum[DATA_WIDTH-1:0];
		else if (sum[DATA_WIDTH])
			sumClamped = WORD_MIN;
		else
			sumClamped = WORD_MAX;
	end

	// Load or accumulate per opcode
	always_ff @(posedge clk)
	begin
		case (command.opcode)
			MAC_MULT: accumulator <= doubled;
			MAC_ACCUM: accumulator <= sumClamped;
			default: accumulator <= accumulator;
		endcase
	end

	// Sticky flag held until cleared by the next start
	always_ff @(posedge clk)
	begin
		if (reset || clearFlag)
			overflow <= 1'b0;
		else if (command.opcode == MAC_MULT && productSaturated)
			overflow <= 1'b1;
		else if (command.opcode == MAC_ACCUM && (productSaturated || sumSaturated))
			overflow <= 1'b1;
	end

	// Opcode from the controller stays within the encoding
	assert property (@(posedge clk) disable iff (reset)
		command.opcode inside {MAC_NONE, MAC_MULT, MAC_ACCUM});

endmodule

// File: src/scratchMemory.sv
module scratchMemory
(
	input logic clk,
	input lspComposePkg::memWrite write,
	input logic [lspComposePkg::ADDR_WIDTH-1:0] readAddr,
	output logic [lspComposePkg::DATA_WIDTH-1:0] readData
);
	import lspComposePkg::*;

	// Word array, maps onto one block RAM
	logic [DATA_WIDTH-1:0] words [0:MEM_DEPTH-1];

	//////////////////////////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////////////////////////

	// Write lands on the clock edge
	always_ff @(posedge clk)
	begin
		if (write.en)
		begin
			words[write.adr] <= write.dat;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read port
	//////////////////////////////////////////////////////////////////////

	// Registered read, one cycle of latency
	// Same-edge write to the read address gives the old word
	always_ff @(posedge clk)
	begin
		readData <= words[readAddr];
	end

endmodule

// File: src/lspComposePkg.sv
package lspComposePkg;

	//////////////////////////////////////////////////////////////////////
	// Sizes
	//////////////////////////////////////////////////////////////////////
	localparam int LSP_ORDER = 10;
	localparam int MA_ORDER = 4;
	localparam int ADDR_WIDTH = 11;
	localparam int DATA_WIDTH = 32;
	localparam int OP_WIDTH = 16;
	localparam int MEM_DEPTH = 1 << ADDR_WIDTH;
	localparam int COEFF_WIDTH = 4;
	localparam int STAGE_WIDTH = 2;

	// Saturation limits of the 32-bit accumulator
	localparam logic [DATA_WIDTH-1:0] WORD_MAX = 32'h7fff_ffff;
	localparam logic [DATA_WIDTH-1:0] WORD_MIN = 32'h8000_0000;

	//////////////////////////////////////////////////////////////////////
	// Scratch memory map, low 16 bits of each word hold the operand
	//////////////////////////////////////////////////////////////////////
	localparam logic [ADDR_WIDTH-1:0] LSP_ELE_BASE = 11'd0;
	localparam logic [ADDR_WIDTH-1:0] FG_SUM_BASE = 11'd16;
	localparam logic [ADDR_WIDTH-1:0] FREQ_PREV_BASE = 11'd32;
	localparam logic [ADDR_WIDTH-1:0] FG_BASE = 11'd96;
	localparam logic [ADDR_WIDTH-1:0] LSP_OUT_BASE = 11'd160;
	// One block of 16 words per predictor stage
	localparam logic [ADDR_WIDTH-1:0] STAGE_STRIDE = 11'd16;

	// Engine sequence
	typedef enum logic [2:0] {IDLE, FETCH_X, FETCH_Y, ACCUMULATE, WRITE_BACK, FINISH} composeState;

	// Arithmetic unit operations
	typedef enum logic [1:0] {MAC_NONE, MAC_MULT, MAC_ACCUM} macOpcode;

	// Wishbone classic master to slave
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [ADDR_WIDTH-1:0] adr;
		logic [DATA_WIDTH-1:0] dat;
	} wbRequest;

	// Wishbone classic slave to master
	typedef struct packed {
		logic ack;
		logic [DATA_WIDTH-1:0] dat;
	} wbResponse;

	// Memory write port bundle
	typedef struct packed {
		logic en;
		logic [ADDR_WIDTH-1:0] adr;
		logic [DATA_WIDTH-1:0] dat;
	} memWrite;

	// Operation plus two Q15 operands
	typedef struct packed {
		macOpcode opcode;
		logic [OP_WIDTH-1:0] operandA;
		logic [OP_WIDTH-1:0] operandB;
	} macCommand;

endpackage
